// File: all.f
stdp_pkg.sv
param_decode.sv
rng_xorshift.sv
current_execute.sv
neuron_input_result.sv
stdp_input_top.sv
tb_checker.sv
tb_stdp_input.sv

// File: Bender.yml
package:
  name: stdp_input

sources:
  - stdp_pkg.sv
  - param_decode.sv
  - rng_xorshift.sv
  - current_execute.sv
  - neuron_input_result.sv
  - stdp_input_top.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_stdp_input.sv

// File: tb_stdp_input.sv
`default_nettype none
`timescale 1ns/10ps

module tb_stdp_input;

    localparam int NROWS   = 19;
    localparam int NONE    = -1;   // row without a strobe
    localparam int TIMEOUT = 8;    // cycles to wait for the checker
    localparam stdp_pkg::ctrl_t TRIG   = 3'b000;
    localparam stdp_pkg::ctrl_t WAVE   = 3'b010;
    localparam stdp_pkg::ctrl_t RESEED = 3'b100;  // reset_sim in trigger mode

    typedef struct packed {
        int                  slot;
        logic                rnd;     // random load word
        logic [31:0]         word;
        stdp_pkg::ctrl_t     ctrl;
        logic [31:0]         wave0;
        logic [31:0]         wave2;
        int                  hold;    // cycles the row is held
        logic                chk;
        stdp_pkg::cur_pair_t exp;
    } row_t;

    logic                ep50trig;
    logic                reset_global;
    logic [15:0]         i_trig;
    logic [15:0]         i_wire_lo;
    logic [15:0]         i_wire_hi;
    stdp_pkg::ctrl_t     i_ctrl;
    logic [31:0]         i_wave0;
    logic [31:0]         i_wave2;
    stdp_pkg::cur_pair_t o_cur;
    logic [31:0]         o_time;
    logic                row_end;
    logic                row_chk;
    stdp_pkg::cur_pair_t row_exp;
    int                  rows_done;
    row_t                rows [NROWS];
    logic [31:0]         rnd_state;
    bit                  timed_out;
    int                  failed;

    stdp_input_top #(
        .SEED_0 (stdp_pkg::SEED_N0),
        .SEED_2 (stdp_pkg::SEED_N2)
    ) i_dut (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .i_ctrl       (i_ctrl),
        .i_wave0      (i_wave0),
        .i_wave2      (i_wave2),
        .o_cur        (o_cur),
        .o_time       (o_time)
    );

    tb_checker #(
        .SEED_0 (stdp_pkg::SEED_N0),
        .SEED_2 (stdp_pkg::SEED_N2)
    ) u_checker (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_load       ({i_wire_hi, i_wire_lo}),
        .i_ctrl       (i_ctrl),
        .i_wave0      (i_wave0),
        .i_wave2      (i_wave2),
        .i_cur        (o_cur),
        .i_time       (o_time),
        .i_row_end    (row_end),
        .i_row_chk    (row_chk),
        .i_row_exp    (row_exp),
        .o_rows_done  (rows_done)
    );

    always #4 ep50trig = ~ep50trig;  // 8 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic row_t make_row(input int slot, input bit rnd, input logic [31:0] word,
                                      input stdp_pkg::ctrl_t ctrl, input logic [31:0] w0,
                                      input logic [31:0] w2, input int hold, input bit chk,
                                      input logic [31:0] e0, input logic [31:0] e2);
        row_t r;
        r.slot   = slot;
        r.rnd    = rnd;
        r.word   = word;
        r.ctrl   = ctrl;
        r.wave0  = w0;
        r.wave2  = w2;
        r.hold   = hold;
        r.chk    = chk;
        r.exp.n0 = e0;
        r.exp.n2 = e2;
        return r;
    endfunction

    // strobe on the first edge and levels for the whole hold
    task automatic apply_row(input int n);
        row_t        r;
        logic [31:0] word;
        int          wait_cnt;
        r    = rows[n];
        word = r.word;
        if (r.rnd)
        begin
            rnd_state = next_random(rnd_state);
            word      = rnd_state;   // never zero
        end
        @(posedge ep50trig);
        i_wire_lo <= word[15:0];
        i_wire_hi <= word[31:16];
        i_ctrl    <= r.ctrl;
        i_wave0   <= r.wave0;
        i_wave2   <= r.wave2;
        if (r.slot != NONE)
            i_trig <= 16'h1 << r.slot;
        repeat (r.hold - 1)
        begin
            @(posedge ep50trig);
            i_trig <= '0;
        end
        @(posedge ep50trig);
        i_trig  <= '0;
        row_end <= 1'b1;
        row_chk <= r.chk;
        row_exp <= r.exp;
        @(posedge ep50trig);
        row_end  <= 1'b0;
        wait_cnt = 0;
        while (rows_done <= n && wait_cnt < TIMEOUT)   // checker closes the row
        begin
            @(posedge ep50trig);
            wait_cnt++;
        end
        if (rows_done <= n)
        begin
            $display("timeout, the checker never closed test %0d", n);
            timed_out = 1'b1;
        end
    endtask

    initial
    begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_trig       = '0;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_ctrl       = TRIG;
        i_wave0      = '0;
        i_wave2      = '0;
        row_end      = 1'b0;
        row_chk      = 1'b0;
        row_exp      = '0;
        rnd_state    = 32'hee885f01;
        timed_out    = 1'b0;
        // slot, rnd, word, ctrl, wave0, wave2, hold, chk, exp n0, exp n2
        rows[0]  = make_row(NONE, 0, 0, TRIG, 0, 0, 6, 0, 0, 0);   // reset defaults
        rows[1]  = make_row(NONE, 0, 0, WAVE, 32'h111, 32'h222, 5, 1, 32'h111, 32'h222);
        rows[2]  = make_row(NONE, 0, 0, WAVE, 32'hdeadbeef, 32'h0badcafe, 4, 1,
                            32'hdeadbeef, 32'h0badcafe);
        rows[3]  = make_row(stdp_pkg::SLOT_DIGIT, 0, 9, TRIG, 0, 0, 8, 0, 0, 0);
        rows[4]  = make_row(stdp_pkg::SLOT_DIGIT, 0, 14, TRIG, 0, 0, 8, 0, 0, 0);
        rows[5]  = make_row(stdp_pkg::SLOT_DIGIT, 0, 5, TRIG, 0, 0, 8, 0, 0, 0);   // 9 bits
        rows[6]  = make_row(stdp_pkg::SLOT_DIGIT, 0, 20, TRIG, 0, 0, 8, 0, 0, 0);  // 9 bits
        rows[7]  = make_row(stdp_pkg::SLOT_DRIVE, 1, 0, TRIG, 0, 0, 6, 0, 0, 0);
        rows[8]  = make_row(stdp_pkg::SLOT_DRIVE, 0, 1000, RESEED, 0, 0, 2, 0, 0, 0);
        rows[9]  = make_row(NONE, 0, 0, TRIG, 0, 0, 6, 0, 0, 0);   // rng back on seed
        rows[10] = make_row(stdp_pkg::SLOT_SYNC, 0, 1, WAVE, 32'h55, 32'h66, 5, 1,
                            32'h55, 32'h55);
        rows[11] = make_row(NONE, 0, 0, TRIG, 0, 0, 6, 0, 0, 0);   // synced jitter
        rows[12] = make_row(stdp_pkg::SLOT_SYNC, 0, 0, WAVE, 32'h77, 32'h88, 5, 1,
                            32'h77, 32'h88);
        rows[13] = make_row(stdp_pkg::SLOT_BLOCK0, 1, 0, WAVE, 32'h99, 32'haa, 5, 1, 0, 32'haa);
        rows[14] = make_row(stdp_pkg::SLOT_BLOCK0, 0, 0, WAVE, 32'h99, 32'haa, 5, 1,
                            32'h99, 32'haa);
        rows[15] = make_row(stdp_pkg::SLOT_BLOCK2, 0, 1, WAVE, 32'h99, 32'haa, 5, 1, 32'h99, 0);
        rows[16] = make_row(stdp_pkg::SLOT_SYNC, 0, 1, WAVE, 32'h99, 32'haa, 5, 1, 32'h99, 0);
        rows[17] = make_row(stdp_pkg::SLOT_BLOCK2, 0, 0, WAVE, 32'h99, 32'haa, 5, 1,
                            32'h99, 32'h99);
        rows[18] = make_row(stdp_pkg::SLOT_SYNC, 0, 0, TRIG, 0, 0, 6, 0, 0, 0);
        repeat (10) @(posedge ep50trig);
        reset_global <= 1'b0;
        for (int n = 0; n < NROWS && !timed_out; n++)
            apply_row(n);
        @(negedge ep50trig);   // checker done with the last edge
        u_checker.print_summary(failed);
        if (failed == 0 && !timed_out)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`default_nettype none
`timescale 1ns/10ps

module tb_checker #(
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_0 = stdp_pkg::SEED_N0,
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_2 = stdp_pkg::SEED_N2
) (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire [stdp_pkg::HALF_W-1:0]   i_trig,
    input  wire [stdp_pkg::DATA_W-1:0]   i_load,      // {hi, lo} as seen by the DUT
    input  wire stdp_pkg::ctrl_t         i_ctrl,
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave0,
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave2,
    input  wire stdp_pkg::cur_pair_t     i_cur,
    input  wire [stdp_pkg::DATA_W-1:0]   i_time,
    input  wire                          i_row_end,   // last cycle of a table row
    input  wire                          i_row_chk,   // row carries fixed expected values
    input  wire stdp_pkg::cur_pair_t     i_row_exp,
    output int                           o_rows_done
);

    // model state, one copy of every DUT register
    logic [stdp_pkg::DATA_W-1:0] digit;
    logic [stdp_pkg::DATA_W-1:0] drive;
    logic [stdp_pkg::DATA_W-1:0] sync;
    logic                        blk0;
    logic                        blk2;
    logic [stdp_pkg::DATA_W-1:0] r0;
    logic [stdp_pkg::DATA_W-1:0] r2;
    stdp_pkg::cur_pair_t         raw;    // stage one
    stdp_pkg::cur_pair_t         cur;    // stage two
    logic [stdp_pkg::DATA_W-1:0] tm;
    int                          w;      // jitter width in bits
    logic [stdp_pkg::DATA_W-1:0] mask;
    int                          row_errs;
    int                          fails;
    int                          errs;

    // 13 / 17 / 5 step
    function automatic logic [31:0] rng_step(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            row_errs++;
        end
    endtask

    // called by the testbench top once the table is done
    task automatic print_summary(output int failed);
        failed = fails + row_errs;  // stray errors after the last row too
        $display("tests %0d, failed %0d, errors %0d", o_rows_done, fails, errs + row_errs);
    endtask

    // all reads here see pre-edge values, the DUT and the stimulus update in NBA
    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            digit = stdp_pkg::DIGIT_RST;
            drive = stdp_pkg::DRIVE_RST;
            sync  = '0;
            blk0  = 1'b0;
            blk2  = 1'b0;
            r0    = SEED_0;
            r2    = SEED_2;
            raw   = '0;
            cur   = '0;   // o_cur zero until the pipe fills
            tm    = '0;
        end
        else
        begin
            compare("o_cur.n0", i_cur.n0, cur.n0);
            compare("o_cur.n2", i_cur.n2, cur.n2);
            compare("o_time", i_time, tm);
            if (i_row_end)
            begin
                if (i_row_chk)
                begin
                    compare("o_cur.n0", i_cur.n0, i_row_exp.n0);
                    compare("o_cur.n2", i_cur.n2, i_row_exp.n2);
                end
                if (row_errs == 0)
                    $display("test %0d ok", o_rows_done);
                else
                    $display("test %0d failed with %0d errors", o_rows_done, row_errs);
                if (row_errs != 0)
                    fails++;
                errs     += row_errs;
                row_errs  = 0;
                o_rows_done <= o_rows_done + 1;
            end
            // stage two from old raw and old params, sync first then block
            cur.n0 = blk0 ? '0 : raw.n0;
            cur.n2 = blk2 ? '0 : ((sync != 0) ? raw.n0 : raw.n2);
            // stage one
            if (digit >= stdp_pkg::DIGIT_MIN && digit <= stdp_pkg::DIGIT_MAX)
                w = int'(digit) + 1;
            else
                w = 9;        // narrow fallback
            mask = (32'h1 << w) - 32'h1;
            if (i_ctrl.wave_sel)
            begin
                raw.n0 = i_wave0;
                raw.n2 = i_wave2;
            end
            else
            begin
                raw.n0 = drive + (r0 & mask);
                raw.n2 = drive + ((r2 >> 16) & mask);  // upper half for n2
            end
            r0 = i_ctrl.reset_sim ? SEED_0 : rng_step(r0);
            r2 = i_ctrl.reset_sim ? SEED_2 : rng_step(r2);
            // params land after the strobe edge
            if (i_trig[stdp_pkg::SLOT_DIGIT])
                digit = i_load;
            if (i_trig[stdp_pkg::SLOT_DRIVE])
                drive = i_load;
            if (i_trig[stdp_pkg::SLOT_SYNC])
                sync = i_load;
            if (i_trig[stdp_pkg::SLOT_BLOCK0])
                blk0 = (i_load != 0);
            if (i_trig[stdp_pkg::SLOT_BLOCK2])
                blk2 = (i_load != 0);
            tm = tm + 1;
        end
    end

endmodule

`default_nettype wire

// File: stdp_input_top.sv
`default_nettype none
`timescale 1ns/10ps

module stdp_input_top #(
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_0 = stdp_pkg::SEED_N0,
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_2 = stdp_pkg::SEED_N2
) (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire [stdp_pkg::HALF_W-1:0]   i_trig,
    input  wire [stdp_pkg::HALF_W-1:0]   i_wire_lo,
    input  wire [stdp_pkg::HALF_W-1:0]   i_wire_hi,
    input  wire stdp_pkg::ctrl_t         i_ctrl,
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave0,
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave2,
    output stdp_pkg::cur_pair_t          o_cur,
    output logic [stdp_pkg::DATA_W-1:0]  o_time
);

    stdp_pkg::params_t   params;   // register bank, feeds both stages
    stdp_pkg::cur_pair_t raw;      // jittered or waveform currents

    param_decode u_decode (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_params     (params)
    );

    current_execute #(
        .SEED_0 (SEED_0),
        .SEED_2 (SEED_2)
    ) u_execute (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_ctrl       (i_ctrl),
        .i_params     (params),
        .i_wave0      (i_wave0),
        .i_wave2      (i_wave2),
        .o_raw        (raw)
    );

    neuron_input_result u_result (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_params     (params),
        .i_raw        (raw),
        .o_cur        (o_cur),
        .o_time       (o_time)
    );

endmodule

`default_nettype wire

// File: neuron_input_result.sv
`default_nettype none
`timescale 1ns/10ps

module neuron_input_result (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire stdp_pkg::params_t       i_params,
    input  wire stdp_pkg::cur_pair_t     i_raw,
    output stdp_pkg::cur_pair_t          o_cur,
    output logic [stdp_pkg::DATA_W-1:0]  o_time    // free-running time tag
);

    logic [stdp_pkg::DATA_W-1:0] n2_pre;  // after sync, before gating
    stdp_pkg::cur_pair_t         cur_d;

    always_comb
    begin
        // sync takes the ungated n0 current
        n2_pre = (|i_params.sync) ? i_raw.n0 : i_raw.n2;

        // gating comes last so a block always wins
        cur_d.n0 = i_params.block0 ? '0 : i_raw.n0;
        cur_d.n2 = i_params.block2 ? '0 : n2_pre;
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_cur <= '0;
        end
        else
        begin
            o_cur <= cur_d;   // second stage
        end
    end

    // time tag for latency measurement
    // only the global reset clears it, reset_sim leaves it running
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_time <= '0;
        end
        else
        begin
            o_time <= o_time + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: current_execute.sv
`default_nettype none
`timescale 1ns/10ps

module current_execute #(
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_0 = stdp_pkg::SEED_N0,
    parameter logic [stdp_pkg::DATA_W-1:0] SEED_2 = stdp_pkg::SEED_N2
) (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire stdp_pkg::ctrl_t         i_ctrl,
    input  wire stdp_pkg::params_t       i_params,
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave0,   // integer waveform samples
    input  wire [stdp_pkg::DATA_W-1:0]   i_wave2,
    output stdp_pkg::cur_pair_t          o_raw
);

    localparam int         N2_LSB     = 16;    // n2 jitter from upper half of its rng
    localparam logic [5:0] JIT_W_DFLT = 6'd9;  // width for out-of-range digits

    logic [stdp_pkg::DATA_W-1:0] rand0;
    logic [stdp_pkg::DATA_W-1:0] rand2;
    logic                        digit_ok;
    logic [5:0]                  jit_w;     // 9..15 bits
    logic [stdp_pkg::DATA_W-1:0] jit_mask;
    logic [stdp_pkg::DATA_W-1:0] jit0;
    logic [stdp_pkg::DATA_W-1:0] jit2;
    stdp_pkg::cur_pair_t         raw_d;

    rng_xorshift #(
        .SEED (SEED_0)
    ) u_rng0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_ctrl.reset_sim),
        .o_rand       (rand0)
    );

    rng_xorshift #(
        .SEED (SEED_2)
    ) u_rng2 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_ctrl.reset_sim),
        .o_rand       (rand2)
    );

    always_comb
    begin
        digit_ok = (i_params.digit >= stdp_pkg::DIGIT_MIN) &&
                   (i_params.digit <= stdp_pkg::DIGIT_MAX);
        // digit d keeps d+1 low bits
        jit_w    = digit_ok ? ({1'b0, i_params.digit[4:0]} + 6'd1) : JIT_W_DFLT;
        jit_mask = ~({stdp_pkg::DATA_W{1'b1}} << jit_w);
        jit0     = rand0 & jit_mask;
        jit2     = (rand2 >> N2_LSB) & jit_mask;   // decorrelated from n0

        if (i_ctrl.wave_sel)
        begin
            raw_d.n0 = i_wave0;   // waveform mode, no jitter
            raw_d.n2 = i_wave2;
        end
        else
        begin
            raw_d.n0 = i_params.drive + jit0;  // wraps like the 32-bit adder
            raw_d.n2 = i_params.drive + jit2;
        end
    end

    // first pipeline stage
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_raw <= '0;  // keeps o_cur clean while filling
        end
        else
        begin
            o_raw <= raw_d;
        end
    end

endmodule

`default_nettype wire

// File: rng_xorshift.sv
`default_nettype none
`timescale 1ns/10ps

module rng_xorshift #(
    parameter logic [stdp_pkg::DATA_W-1:0] SEED = stdp_pkg::SEED_N0  // must be nonzero
) (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire                          i_reset_sim,  // sync reseed
    output logic [stdp_pkg::DATA_W-1:0]  o_rand
);

    logic [stdp_pkg::DATA_W-1:0] state_q;
    logic [stdp_pkg::DATA_W-1:0] state_d;

    // 13 / 17 / 5 xorshift step
    always_comb
    begin
        state_d = state_q ^ (state_q << 13);
        state_d = state_d ^ (state_d >> 17);
        state_d = state_d ^ (state_d << 5);
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            state_q <= SEED;
        end
        else
        begin
            state_q <= i_reset_sim ? SEED : state_d;  // steps every cycle
        end
    end

    assign o_rand = state_q;  // current state, not the next one

endmodule

`default_nettype wire

// File: param_decode.sv
`default_nettype none
`timescale 1ns/10ps

module param_decode (
    input  wire                           ep50trig,
    input  wire                           reset_global,
    input  wire  [stdp_pkg::HALF_W-1:0]   i_trig,      // one-cycle strobes
    input  wire  [stdp_pkg::HALF_W-1:0]   i_wire_lo,
    input  wire  [stdp_pkg::HALF_W-1:0]   i_wire_hi,
    output stdp_pkg::params_t             o_params
);

    logic [stdp_pkg::DATA_W-1:0] load_word;  // {hi, lo} shared by every slot
    logic                        load_nz;    // block flags only keep nonzero-ness

    assign load_word = {i_wire_hi, i_wire_lo};
    assign load_nz   = |load_word;

    // parameter bank
    // slots are independent so two strobes in one cycle both land
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_params.digit  <= stdp_pkg::DIGIT_RST;
            o_params.drive  <= stdp_pkg::DRIVE_RST;
            o_params.sync   <= '0;    // inputs independent
            o_params.block0 <= 1'b0;
            o_params.block2 <= 1'b0;
        end
        else
        begin
            if (i_trig[stdp_pkg::SLOT_DIGIT])
            begin
                o_params.digit <= load_word;
            end
            if (i_trig[stdp_pkg::SLOT_DRIVE])
            begin
                o_params.drive <= load_word;
            end
            if (i_trig[stdp_pkg::SLOT_SYNC])
            begin
                o_params.sync <= load_word;
            end
            if (i_trig[stdp_pkg::SLOT_BLOCK0])
            begin
                o_params.block0 <= load_nz;
            end
            if (i_trig[stdp_pkg::SLOT_BLOCK2])
            begin
                o_params.block2 <= load_nz;
            end
        end
    end

endmodule

`default_nettype wire

// File: stdp_pkg.sv
`default_nettype none

package stdp_pkg;

    localparam int DATA_W = 32;  // currents and parameter words
    localparam int HALF_W = 16;  // one host wire

    // bit positions inside the trigger strobe vector
    typedef enum logic [3:0] {
        SLOT_DIGIT  = 4'd2,   // random digit, jitter width
        SLOT_SYNC   = 4'd3,   // copy n0 drive onto n2
        SLOT_BLOCK0 = 4'd4,   // silence neuron 0
        SLOT_DRIVE  = 4'd6,   // base drive current
        SLOT_BLOCK2 = 4'd8    // silence neuron 2
    } trig_slot_e;

    // power-up values of the parameter bank
    localparam logic [DATA_W-1:0] DIGIT_RST = 32'd13;
    localparam logic [DATA_W-1:0] DRIVE_RST = 32'd1600;

    // digits outside this window fall back to the narrow jitter
    localparam logic [DATA_W-1:0] DIGIT_MIN = 32'd9;
    localparam logic [DATA_W-1:0] DIGIT_MAX = 32'd14;

    localparam logic [DATA_W-1:0] SEED_N0 = 32'h1234_5678;
    localparam logic [DATA_W-1:0] SEED_N2 = 32'h8765_4321;

    // level controls from host wire 00
    typedef struct packed {
        logic reset_sim;  // reseed both rngs
        logic wave_sel;   // high selects the waveform sample
        logic spare;      // unassigned bit of the wire
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] digit;   // jitter width select
        logic [DATA_W-1:0] drive;   // base current
        logic [DATA_W-1:0] sync;    // nonzero ties n2 to n0
        logic              block0;
        logic              block2;
    } params_t;

    typedef struct packed {
        logic [DATA_W-1:0] n0;
        logic [DATA_W-1:0] n2;
    } cur_pair_t;

endpackage

`default_nettype wire
